// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0 --timescale 1ns/1ps
TOP       = tb_exu
FILELIST  = src.f
OBJ_DIR   = obj_dir
PASS_MSG  = all tests passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: exu_alu.sv
`timescale 1ns/1ps

module exu_alu (
   input  exu_pkg::alu_op_t                 op,
   input  logic [exu_pkg::XLEN-1:0]         a,
   input  logic [exu_pkg::XLEN-1:0]         b,
   output logic [exu_pkg::XLEN-1:0]         result
);

   logic [4:0]                shamt;
   logic [exu_pkg::XLEN-1:0]  sum;
   logic [exu_pkg::XLEN-1:0]  diff;
   logic                      lt_signed;
   logic                      lt_unsigned;

   // only the low five bits of b count for shifts
   assign shamt = b[4:0];

   assign sum  = a + b;
   assign diff = a - b;

   assign lt_signed   = $signed(a) < $signed(b);
   assign lt_unsigned = a < b;

   always_comb begin
      unique case (op)
         exu_pkg::ALU_ADD: begin
            result = sum;
         end
         exu_pkg::ALU_SUB: begin
            result = diff;
         end
         exu_pkg::ALU_SLT: begin
            result = {{(exu_pkg::XLEN-1){1'b0}}, lt_signed};
         end
         exu_pkg::ALU_SLTU: begin
            result = {{(exu_pkg::XLEN-1){1'b0}}, lt_unsigned};
         end
         exu_pkg::ALU_AND: begin
            result = a & b;
         end
         exu_pkg::ALU_OR: begin
            result = a | b;
         end
         exu_pkg::ALU_XOR: begin
            result = a ^ b;
         end
         exu_pkg::ALU_NOR: begin
            result = ~(a | b);
         end
         exu_pkg::ALU_SLL: begin
            result = a << shamt;
         end
         exu_pkg::ALU_SRL: begin
            result = a >> shamt;
         end
         exu_pkg::ALU_SRA: begin
            result = $unsigned($signed(a) >>> shamt);
         end
         // immediate already shifted by decode
         exu_pkg::ALU_LUI: begin
            result = b;
         end
         default: begin
            result = '0;
         end
      endcase
   end

endmodule

// File: exu_branch.sv
`timescale 1ns/1ps

module exu_branch (
   input  logic                             valid,
   input  exu_pkg::bru_op_t                 op,
   input  logic [exu_pkg::XLEN-1:0]         a,
   input  logic [exu_pkg::XLEN-1:0]         b,
   input  logic [exu_pkg::XLEN-1:0]         pc,
   input  logic [exu_pkg::XLEN-1:0]         offset,
   output logic                             taken,
   output logic [exu_pkg::XLEN-1:0]         target,
   output logic [exu_pkg::XLEN-1:0]         link
);

   logic cond;

   // condition per op
   always_comb begin
      unique case (op)
         exu_pkg::BRU_BEQ: begin
            cond = (a == b);
         end
         exu_pkg::BRU_BNE: begin
            cond = (a != b);
         end
         exu_pkg::BRU_BLT: begin
            cond = ($signed(a) < $signed(b));
         end
         exu_pkg::BRU_BGE: begin
            cond = ($signed(a) >= $signed(b));
         end
         exu_pkg::BRU_BLTU: begin
            cond = (a < b);
         end
         exu_pkg::BRU_BGEU: begin
            cond = (a >= b);
         end
         exu_pkg::BRU_B, exu_pkg::BRU_BL, exu_pkg::BRU_JIRL: begin
            cond = 1'b1;
         end
         default: begin
            cond = 1'b0;
         end
      endcase
   end

   assign taken = valid & cond;

   // jirl is register relative, the rest pc relative
   assign target = (op == exu_pkg::BRU_JIRL) ? (a + offset) : (pc + offset);

   assign link = pc + exu_pkg::LINK_OFFSET;

endmodule

// File: exu_bypass.sv
`timescale 1ns/1ps

module exu_bypass (
   input  logic [exu_pkg::REG_ADDR_W-1:0]   rs1,
   input  logic [exu_pkg::REG_ADDR_W-1:0]   rs2,
   input  logic [exu_pkg::XLEN-1:0]         rs1_data,
   input  logic [exu_pkg::XLEN-1:0]         rs2_data,
   input  logic [exu_pkg::REG_ADDR_W-1:0]   rd_m,
   input  logic [exu_pkg::REG_ADDR_W-1:0]   rd_w,
   input  logic                             wen_m,
   input  logic                             wen_w,
   input  logic [exu_pkg::XLEN-1:0]         rd_data_m,
   input  logic [exu_pkg::XLEN-1:0]         rd_data_w,
   output logic [exu_pkg::XLEN-1:0]         rs1_fwd,
   output logic [exu_pkg::XLEN-1:0]         rs2_fwd
);

   // newest producer wins: M, then W, then the file value
   function automatic logic [exu_pkg::XLEN-1:0] select(
      input logic [exu_pkg::REG_ADDR_W-1:0] rs,
      input logic [exu_pkg::XLEN-1:0]       rf_data
   );
      logic [exu_pkg::XLEN-1:0] data;
      if (rs == '0) begin
         data = rf_data;
      end else if (wen_m && (rd_m == rs)) begin
         data = rd_data_m;
      end else if (wen_w && (rd_w == rs)) begin
         data = rd_data_w;
      end else begin
         data = rf_data;
      end
      return data;
   endfunction

   assign rs1_fwd = select(rs1, rs1_data);
   assign rs2_fwd = select(rs2, rs2_data);

endmodule

// File: exu_pkg.sv
package exu_pkg;

   // data path and address width
   localparam int XLEN = 32;

   // 32 integer registers
   localparam int REG_ADDR_W = 5;

   // link value is the address of the next instruction
   localparam logic [XLEN-1:0] LINK_OFFSET = 32'd4;

   // alu operations, lui hands operand b through
   typedef enum logic [3:0] {
      ALU_ADD  = 4'd0,
      ALU_SUB  = 4'd1,
      ALU_SLT  = 4'd2,
      ALU_SLTU = 4'd3,
      ALU_AND  = 4'd4,
      ALU_OR   = 4'd5,
      ALU_XOR  = 4'd6,
      ALU_NOR  = 4'd7,
      ALU_SLL  = 4'd8,
      ALU_SRL  = 4'd9,
      ALU_SRA  = 4'd10,
      ALU_LUI  = 4'd11
   } alu_op_t;

   // branch operations
   // b and bl are unconditional, jirl jumps relative to rs1
   typedef enum logic [3:0] {
      BRU_BEQ  = 4'd0,
      BRU_BNE  = 4'd1,
      BRU_BLT  = 4'd2,
      BRU_BGE  = 4'd3,
      BRU_BLTU = 4'd4,
      BRU_BGEU = 4'd5,
      BRU_B    = 4'd6,
      BRU_BL   = 4'd7,
      BRU_JIRL = 4'd8
   } bru_op_t;

endpackage

// File: exu_regfile.sv
`timescale 1ns/1ps

module exu_regfile (
   input  logic                             clk,
   input  logic                             reset,
   input  logic [exu_pkg::REG_ADDR_W-1:0]   raddr1,
   input  logic [exu_pkg::REG_ADDR_W-1:0]   raddr2,
   output logic [exu_pkg::XLEN-1:0]         rdata1,
   output logic [exu_pkg::XLEN-1:0]         rdata2,
   input  logic                             wen,
   input  logic [exu_pkg::REG_ADDR_W-1:0]   waddr,
   input  logic [exu_pkg::XLEN-1:0]         wdata
);

   // register 0 has no storage
   logic [exu_pkg::XLEN-1:0] regs [1:31];

   // one read port, with the write of this cycle passed through
   function automatic logic [exu_pkg::XLEN-1:0] read_port(
      input logic [exu_pkg::REG_ADDR_W-1:0] addr
   );
      logic [exu_pkg::XLEN-1:0] data;
      if (addr == '0) begin
         data = '0;
      end else if (wen && (addr == waddr)) begin
         data = wdata;
      end else begin
         data = regs[addr];
      end
      return data;
   endfunction

   assign rdata1 = read_port(raddr1);
   assign rdata2 = read_port(raddr2);

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 1; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (wen && (waddr != '0)) begin
         regs[waddr] <= wdata;
      end
   end

endmodule

// File: exu_top.sv
`timescale 1ns/1ps

module exu_top (
   input  logic                             clk,
   input  logic                             reset,

   // decode stage
   input  logic                             issue_valid,
   input  logic [exu_pkg::XLEN-1:0]         issue_pc,
   input  logic [exu_pkg::REG_ADDR_W-1:0]   issue_rs1,
   input  logic [exu_pkg::REG_ADDR_W-1:0]   issue_rs2,
   input  logic [exu_pkg::REG_ADDR_W-1:0]   issue_rd,
   input  logic                             issue_wen,
   input  logic [exu_pkg::XLEN-1:0]         issue_imm,

   input  logic                             issue_alu_valid,
   input  exu_pkg::alu_op_t                 issue_alu_op,
   input  logic                             issue_alu_a_pc,
   input  logic                             issue_alu_b_imm,

   input  logic                             issue_bru_valid,
   input  exu_pkg::bru_op_t                 issue_bru_op,
   input  logic [exu_pkg::XLEN-1:0]         issue_bru_offset,

   // redirect to fetch
   output logic                             branch,
   output logic [exu_pkg::XLEN-1:0]         branch_addr,

   // retired register write
   output logic                             wb_valid,
   output logic [exu_pkg::REG_ADDR_W-1:0]   wb_rd,
   output logic [exu_pkg::XLEN-1:0]         wb_data
);

   logic [exu_pkg::XLEN-1:0]        rs1_data_d, rs2_data_d;
   logic                            accept_d;
   logic                            flush;

   // E stage
   logic                            wen_e, alu_valid_e, bru_valid_e;
   logic [exu_pkg::XLEN-1:0]        pc_e, imm_e, bru_offset_e;
   logic [exu_pkg::REG_ADDR_W-1:0]  rs1_e, rs2_e, rd_e;
   logic [exu_pkg::XLEN-1:0]        rs1_data_e, rs2_data_e;
   logic [exu_pkg::XLEN-1:0]        rs1_fwd_e, rs2_fwd_e;
   exu_pkg::alu_op_t                alu_op_e;
   exu_pkg::bru_op_t                bru_op_e;
   logic                            alu_a_pc_e, alu_b_imm_e;
   logic [exu_pkg::XLEN-1:0]        alu_a_e, alu_b_e, alu_res_e;
   logic                            taken_e;
   logic [exu_pkg::XLEN-1:0]        target_e, link_e;

   // M stage
   logic                            wen_m, alu_valid_m, bru_valid_m, taken_m;
   logic [exu_pkg::REG_ADDR_W-1:0]  rd_m;
   logic [exu_pkg::XLEN-1:0]        alu_res_m, link_m, target_m, rd_data_m;

   // W stage
   logic                            wen_w, taken_w;
   logic [exu_pkg::REG_ADDR_W-1:0]  rd_w;
   logic [exu_pkg::XLEN-1:0]        rd_data_w, target_w;

   exu_regfile u_rf (
      .clk      (clk),
      .reset    (reset),
      .raddr1   (issue_rs1),
      .raddr2   (issue_rs2),
      .rdata1   (rs1_data_d),
      .rdata2   (rs2_data_d),
      .wen      (wen_w),
      .waddr    (rd_w),
      .wdata    (rd_data_w)
   );

   // a taken branch anywhere in E, M or W kills the issuing instruction
   assign flush    = taken_e | taken_m | taken_w;
   assign accept_d = issue_valid & ~flush;

   always_ff @(posedge clk) begin
      if (reset) begin
         wen_e       <= 1'b0;
         alu_valid_e <= 1'b0;
         bru_valid_e <= 1'b0;
      end else begin
         // writes to register 0 are dropped here
         wen_e       <= issue_wen & accept_d & (issue_rd != '0);
         alu_valid_e <= issue_alu_valid & accept_d;
         bru_valid_e <= issue_bru_valid & accept_d;
      end
   end

   always_ff @(posedge clk) begin
      pc_e         <= issue_pc;
      rs1_e        <= issue_rs1;
      rs2_e        <= issue_rs2;
      rd_e         <= issue_rd;
      rs1_data_e   <= rs1_data_d;
      rs2_data_e   <= rs2_data_d;
      imm_e        <= issue_imm;
      alu_op_e     <= issue_alu_op;
      alu_a_pc_e   <= issue_alu_a_pc;
      alu_b_imm_e  <= issue_alu_b_imm;
      bru_op_e     <= issue_bru_op;
      bru_offset_e <= issue_bru_offset;
   end

   exu_bypass u_byp (
      .rs1        (rs1_e),
      .rs2        (rs2_e),
      .rs1_data   (rs1_data_e),
      .rs2_data   (rs2_data_e),
      .rd_m       (rd_m),
      .rd_w       (rd_w),
      .wen_m      (wen_m),
      .wen_w      (wen_w),
      .rd_data_m  (rd_data_m),
      .rd_data_w  (rd_data_w),
      .rs1_fwd    (rs1_fwd_e),
      .rs2_fwd    (rs2_fwd_e)
   );

   assign alu_a_e = alu_a_pc_e ? pc_e : rs1_fwd_e;
   assign alu_b_e = alu_b_imm_e ? imm_e : rs2_fwd_e;

   exu_alu u_alu (
      .op      (alu_op_e),
      .a       (alu_a_e),
      .b       (alu_b_e),
      .result  (alu_res_e)
   );

   exu_branch u_bru (
      .valid   (bru_valid_e),
      .op      (bru_op_e),
      .a       (rs1_fwd_e),
      .b       (rs2_fwd_e),
      .pc      (pc_e),
      .offset  (bru_offset_e),
      .taken   (taken_e),
      .target  (target_e),
      .link    (link_e)
   );

   // rd_m and rd_w reset so that nothing is forwarded out of reset
   always_ff @(posedge clk) begin
      if (reset) begin
         wen_m       <= 1'b0;
         rd_m        <= '0;
         alu_valid_m <= 1'b0;
         bru_valid_m <= 1'b0;
         taken_m     <= 1'b0;
         wen_w       <= 1'b0;
         rd_w        <= '0;
         taken_w     <= 1'b0;
      end else begin
         wen_m       <= wen_e;
         rd_m        <= rd_e;
         alu_valid_m <= alu_valid_e;
         bru_valid_m <= bru_valid_e;
         taken_m     <= taken_e;
         wen_w       <= wen_m;
         rd_w        <= rd_m;
         taken_w     <= taken_m;
      end
   end

   always_ff @(posedge clk) begin
      alu_res_m <= alu_res_e;
      link_m    <= link_e;
      target_m  <= target_e;
      rd_data_w <= rd_data_m;
      target_w  <= target_m;
   end

   // one unit owns the result, the other contributes zero
   assign rd_data_m = ({exu_pkg::XLEN{alu_valid_m}} & alu_res_m) |
                      ({exu_pkg::XLEN{bru_valid_m}} & link_m);

   assign branch      = taken_w;
   assign branch_addr = target_w;

   assign wb_valid = wen_w;
   assign wb_rd    = rd_w;
   assign wb_data  = rd_data_w;

endmodule

// File: src.f
exu_pkg.sv
exu_regfile.sv
exu_bypass.sv
exu_alu.sv
exu_branch.sv
exu_top.sv
tb_exu_checker.sv
tb_exu_asserts.sv
tb_exu.sv

// File: tb_exu.sv
`timescale 1ns/1ps

module tb_exu;

   typedef logic [exu_pkg::XLEN-1:0]       word_t;
   typedef logic [exu_pkg::REG_ADDR_W-1:0] reg_t;

   localparam word_t PC_BASE = 32'h0000_1000;

   // one issue slot plus what it should retire
   typedef struct packed {
      logic             valid;
      word_t            pc;
      reg_t             rs1;
      reg_t             rs2;
      reg_t             rd;
      logic             wen;
      word_t            imm;
      logic             alu_v;
      exu_pkg::alu_op_t alu_op;
      logic             a_pc;
      logic             b_imm;
      logic             bru_v;
      exu_pkg::bru_op_t bru_op;
      word_t            off;
      logic             exp_wb;
      word_t            exp_data;
      logic             exp_taken;
      word_t            exp_target;
   } row_t;

   logic             clk = 1'b0;
   logic             reset;
   logic             issue_valid;
   word_t            issue_pc;
   reg_t             issue_rs1;
   reg_t             issue_rs2;
   reg_t             issue_rd;
   logic             issue_wen;
   word_t            issue_imm;
   logic             issue_alu_valid;
   exu_pkg::alu_op_t issue_alu_op;
   logic             issue_alu_a_pc;
   logic             issue_alu_b_imm;
   logic             issue_bru_valid;
   exu_pkg::bru_op_t issue_bru_op;
   word_t            issue_bru_offset;
   logic             branch;
   word_t            branch_addr;
   logic             wb_valid;
   reg_t             wb_rd;
   word_t            wb_data;

   row_t  rows[$];
   logic  table_ready = 1'b0;
   int    kill;
   int    limit;
   int    missing;
   int    total;
   word_t rnd_a;
   word_t rnd_b;
   word_t bl_pc;

   always #20 clk = ~clk;

   exu_top i_dut (.*);

   tb_exu_checker i_chk (.*);

   bind exu_top tb_exu_asserts i_asserts (
      .clk      (clk),
      .reset    (reset),
      .wb_valid (wb_valid),
      .wb_rd    (wb_rd),
      .branch   (branch)
   );

   function automatic word_t next_pc();
      return PC_BASE + (word_t'(rows.size()) << 2);
   endfunction

   task automatic idle_row();
      row_t r;
      r = '0;
      r.pc = next_pc();
      rows.push_back(r);
   endtask

   task automatic alu_row(input reg_t rd, input reg_t rs1, input reg_t rs2,
                          input exu_pkg::alu_op_t op, input logic a_pc, input logic b_imm,
                          input word_t imm, input word_t exp);
      row_t r;
      r = '0;
      r.valid    = 1'b1;
      r.pc       = next_pc();
      r.rs1      = rs1;
      r.rs2      = rs2;
      r.rd       = rd;
      r.wen      = 1'b1;
      r.imm      = imm;
      r.alu_v    = 1'b1;
      r.alu_op   = op;
      r.a_pc     = a_pc;
      r.b_imm    = b_imm;
      // register 0 never retires
      r.exp_wb   = (rd != '0);
      r.exp_data = exp;
      rows.push_back(r);
   endtask

   task automatic bru_row(input exu_pkg::bru_op_t op, input reg_t rs1, input reg_t rs2,
                          input reg_t rd, input word_t off, input logic taken,
                          input word_t target);
      row_t r;
      r = '0;
      r.valid      = 1'b1;
      r.pc         = next_pc();
      r.rs1        = rs1;
      r.rs2        = rs2;
      r.rd         = rd;
      r.wen        = (rd != '0);
      r.bru_v      = 1'b1;
      r.bru_op     = op;
      r.off        = off;
      r.exp_wb     = (rd != '0);
      // link is pc plus 4
      r.exp_data   = r.pc + 32'd4;
      r.exp_taken  = taken;
      r.exp_target = target;
      rows.push_back(r);
   endtask

   task automatic build_table();
      repeat (3) idle_row();
      alu_row(5'd1, 5'd0, 5'd0, exu_pkg::ALU_LUI, 1'b0, 1'b1, 32'h1234_5000, 32'h1234_5000);
      alu_row(5'd2, 5'd0, 5'd0, exu_pkg::ALU_LUI, 1'b0, 1'b1, rnd_a, rnd_a);
      alu_row(5'd3, 5'd0, 5'd0, exu_pkg::ALU_ADD, 1'b0, 1'b1, 32'h7ff, 32'h7ff);
      // r1 at distance 3, r3 at distance 1
      alu_row(5'd4, 5'd1, 5'd3, exu_pkg::ALU_ADD, 1'b0, 1'b0, '0, 32'h1234_57ff);
      // r4 at distance 1, r3 at distance 2
      alu_row(5'd5, 5'd4, 5'd3, exu_pkg::ALU_SUB, 1'b0, 1'b0, '0, 32'h1234_5000);
      alu_row(5'd6, 5'd0, 5'd0, exu_pkg::ALU_LUI, 1'b0, 1'b1, 32'hffff_f000, 32'hffff_f000);
      alu_row(5'd7, 5'd6, 5'd3, exu_pkg::ALU_SLT, 1'b0, 1'b0, '0, 32'd1);
      alu_row(5'd8, 5'd6, 5'd3, exu_pkg::ALU_SLTU, 1'b0, 1'b0, '0, 32'd0);
      alu_row(5'd9, 5'd4, 5'd3, exu_pkg::ALU_AND, 1'b0, 1'b0, '0, 32'h7ff);
      alu_row(5'd10, 5'd1, 5'd3, exu_pkg::ALU_OR, 1'b0, 1'b0, '0, 32'h1234_57ff);
      alu_row(5'd11, 5'd4, 5'd1, exu_pkg::ALU_XOR, 1'b0, 1'b0, '0, 32'h7ff);
      alu_row(5'd12, 5'd1, 5'd3, exu_pkg::ALU_NOR, 1'b0, 1'b0, '0, 32'hedcb_a800);
      alu_row(5'd13, 5'd3, 5'd0, exu_pkg::ALU_SLL, 1'b0, 1'b1, 32'd4, 32'h7ff0);
      alu_row(5'd14, 5'd6, 5'd0, exu_pkg::ALU_SRL, 1'b0, 1'b1, 32'd8, 32'h00ff_fff0);
      alu_row(5'd15, 5'd6, 5'd0, exu_pkg::ALU_SRA, 1'b0, 1'b1, 32'd8, 32'hffff_fff0);
      alu_row(5'd16, 5'd0, 5'd0, exu_pkg::ALU_ADD, 1'b1, 1'b1, 32'h40, next_pc() + 32'h40);
      alu_row(5'd17, 5'd2, 5'd0, exu_pkg::ALU_XOR, 1'b0, 1'b1, rnd_b, rnd_a ^ rnd_b);
      alu_row(5'd18, 5'd2, 5'd17, exu_pkg::ALU_ADD, 1'b0, 1'b0, '0, rnd_a + (rnd_a ^ rnd_b));
      // shift amount 0x7ff0 keeps only 16
      alu_row(5'd19, 5'd3, 5'd13, exu_pkg::ALU_SLL, 1'b0, 1'b0, '0, 32'h07ff_0000);
      alu_row(5'd20, 5'd3, 5'd6, exu_pkg::ALU_SUB, 1'b0, 1'b0, '0, 32'h0000_17ff);
      alu_row(5'd0, 5'd3, 5'd3, exu_pkg::ALU_ADD, 1'b0, 1'b0, '0, 32'h0ffe);
      alu_row(5'd21, 5'd0, 5'd0, exu_pkg::ALU_ADD, 1'b0, 1'b1, 32'd5, 32'd5);
      alu_row(5'd22, 5'd0, 5'd3, exu_pkg::ALU_OR, 1'b0, 1'b0, '0, 32'h7ff);
      bru_row(exu_pkg::BRU_BEQ, 5'd9, 5'd11, 5'd0, 32'h80, 1'b1, next_pc() + 32'h80);
      alu_row(5'd9, 5'd0, 5'd0, exu_pkg::ALU_ADD, 1'b0, 1'b1, 32'hdead, 32'hdead);
      bru_row(exu_pkg::BRU_B, 5'd0, 5'd0, 5'd0, 32'h40, 1'b1, next_pc() + 32'h40);
      idle_row();
      bru_row(exu_pkg::BRU_BNE, 5'd9, 5'd11, 5'd0, 32'h80, 1'b0, '0);
      alu_row(5'd23, 5'd9, 5'd0, exu_pkg::ALU_ADD, 1'b0, 1'b1, 32'd1, 32'h800);
      bru_row(exu_pkg::BRU_BLT, 5'd6, 5'd3, 5'd0, 32'h24, 1'b1, next_pc() + 32'h24);
      idle_row();
      alu_row(5'd23, 5'd0, 5'd0, exu_pkg::ALU_ADD, 1'b0, 1'b1, 32'h55, 32'h55);
      alu_row(5'd24, 5'd0, 5'd0, exu_pkg::ALU_ADD, 1'b0, 1'b1, 32'h66, 32'h66);
      bru_row(exu_pkg::BRU_BGE, 5'd6, 5'd3, 5'd0, 32'h24, 1'b0, '0);
      bru_row(exu_pkg::BRU_BLTU, 5'd3, 5'd6, 5'd0, 32'h200, 1'b1, next_pc() + 32'h200);
      alu_row(5'd3, 5'd0, 5'd0, exu_pkg::ALU_ADD, 1'b0, 1'b1, 32'd1, 32'd1);
      repeat (2) idle_row();
      bru_row(exu_pkg::BRU_BGEU, 5'd3, 5'd6, 5'd0, 32'h200, 1'b0, '0);
      alu_row(5'd24, 5'd3, 5'd0, exu_pkg::ALU_ADD, 1'b0, 1'b1, 32'd1, 32'h800);
      // branch operand through the M bypass
      bru_row(exu_pkg::BRU_BEQ, 5'd24, 5'd23, 5'd0, 32'h10, 1'b1, next_pc() + 32'h10);
      repeat (3) idle_row();
      bru_row(exu_pkg::BRU_B, 5'd0, 5'd0, 5'd0, 32'hffff_ffe0, 1'b1, next_pc() - 32'h20);
      repeat (3) idle_row();
      bl_pc = next_pc();
      bru_row(exu_pkg::BRU_BL, 5'd0, 5'd0, 5'd25, 32'h100, 1'b1, next_pc() + 32'h100);
      repeat (3) idle_row();
      alu_row(5'd26, 5'd25, 5'd0, exu_pkg::ALU_ADD, 1'b0, 1'b1, '0, bl_pc + 32'd4);
      bru_row(exu_pkg::BRU_JIRL, 5'd1, 5'd0, 5'd27, 32'h10, 1'b1, 32'h1234_5010);
      repeat (3) idle_row();
      // killed writes left r3 and r9 alone
      alu_row(5'd28, 5'd3, 5'd9, exu_pkg::ALU_ADD, 1'b0, 1'b0, '0, 32'h0ffe);
      // r29 written twice in a row and read while both copies are in flight
      alu_row(5'd29, 5'd0, 5'd0, exu_pkg::ALU_ADD, 1'b0, 1'b1, 32'd1, 32'd1);
      alu_row(5'd29, 5'd0, 5'd0, exu_pkg::ALU_ADD, 1'b0, 1'b1, 32'd2, 32'd2);
      alu_row(5'd30, 5'd29, 5'd29, exu_pkg::ALU_ADD, 1'b0, 1'b0, '0, 32'd4);
      repeat (2) idle_row();
   endtask

   task automatic drive_row(input row_t r);
      issue_valid      = r.valid;
      issue_pc         = r.pc;
      issue_rs1        = r.rs1;
      issue_rs2        = r.rs2;
      issue_rd         = r.rd;
      issue_wen        = r.wen;
      issue_imm        = r.imm;
      issue_alu_valid  = r.alu_v;
      issue_alu_op     = r.alu_op;
      issue_alu_a_pc   = r.a_pc;
      issue_alu_b_imm  = r.b_imm;
      issue_bru_valid  = r.bru_v;
      issue_bru_op     = r.bru_op;
      issue_bru_offset = r.off;
   endtask

   initial begin
      void'($urandom(47));
      reset = 1'b1;
      drive_row('0);
      rnd_a = $urandom();
      rnd_b = $urandom();
      build_table();
      table_ready = 1'b1;
      repeat (5) @(posedge clk);
      #1;
      reset = 1'b0;
      kill = 0;
      foreach (rows[i]) begin
         drive_row(rows[i]);
         // slots behind a taken branch are killed
         if (kill > 0) begin
            kill--;
         end else if (rows[i].valid) begin
            i_chk.push_expect(rows[i].exp_wb, rows[i].rd, rows[i].exp_data,
                              rows[i].exp_taken, rows[i].exp_target);
            if (rows[i].exp_taken) begin
               kill = 3;
            end
         end
         @(posedge clk);
         #1;
      end
      repeat (4) @(posedge clk);
      @(negedge clk);
      missing = i_chk.pending();
      if (missing > 0) begin
         $display("%0d expected results were never checked", missing);
      end
      total = i_chk.errors + missing + i_dut.i_asserts.fail_count;
      $display("checks %0d, errors %0d", i_chk.checks, total);
      if (total == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

   // watchdog sized from the table length
   initial begin
      wait (table_ready);
      limit = (rows.size() + 20) * 40;
      #limit;
      $display("timeout, the run did not finish within %0d ns", limit);
      $display("tests failed");
      $finish;
   end

endmodule

// File: tb_exu_asserts.sv
`timescale 1ns/1ps

module tb_exu_asserts (
   input logic                           clk,
   input logic                           reset,
   input logic                           wb_valid,
   input logic [exu_pkg::REG_ADDR_W-1:0] wb_rd,
   input logic                           branch
);

   // failed assertion count
   int fail_count = 0;

   // a retired write never names register 0
   a_rd_nonzero: assert property (@(posedge clk) wb_valid |-> (wb_rd != '0))
      else begin
         fail_count++;
         $error("wb_valid raised for register 0");
      end

   // quiet while reset is held
   a_quiet_in_reset: assert property (@(posedge clk) $past(reset) |-> (!wb_valid && !branch))
      else begin
         fail_count++;
         $error("output active during reset");
      end

   // the three slots behind a taken branch stay silent
   a_branch_shadow: assert property (@(posedge clk)
      ($past(branch, 1) || $past(branch, 2) || $past(branch, 3)) |-> (!wb_valid && !branch))
      else begin
         fail_count++;
         $error("result retired in a slot behind a taken branch");
      end

endmodule

// File: tb_exu_checker.sv
`timescale 1ns/1ps

module tb_exu_checker (
   input logic                           clk,
   input logic                           reset,
   input logic                           wb_valid,
   input logic [exu_pkg::REG_ADDR_W-1:0] wb_rd,
   input logic [exu_pkg::XLEN-1:0]       wb_data,
   input logic                           branch,
   input logic [exu_pkg::XLEN-1:0]       branch_addr
);

   typedef logic [exu_pkg::XLEN-1:0]       word_t;
   typedef logic [exu_pkg::REG_ADDR_W-1:0] reg_t;

   typedef struct packed {
      logic [31:0] due;
      logic        wb;
      reg_t        rd;
      word_t       data;
      logic        taken;
      word_t       target;
   } expect_t;

   expect_t pending_q[$];
   int      cycle = 0;
   int      checks = 0;
   int      errors = 0;

   always @(posedge clk) begin
      cycle <= cycle + 1;
   end

   // results retire three edges after the issuing edge
   task automatic push_expect(input logic wb, input reg_t rd, input word_t data,
                              input logic taken, input word_t target);
      expect_t e;
      e.due    = 32'(cycle + 3);
      e.wb     = wb;
      e.rd     = rd;
      e.data   = data;
      e.taken  = taken;
      e.target = target;
      pending_q.push_back(e);
   endtask

   function automatic int pending();
      return pending_q.size();
   endfunction

   task automatic check_value(input string name, input word_t exp, input word_t act);
      checks++;
      if (exp !== act) begin
         errors++;
         $display("Error at %0t: %s expected %h, got %h", $time, name, exp, act);
      end
   endtask

   // outputs settle by the falling edge
   always @(negedge clk) begin
      expect_t e;
      if (!reset) begin
         if ((pending_q.size() > 0) && (pending_q[0].due == 32'(cycle))) begin
            e = pending_q.pop_front();
            check_value("wb_valid", word_t'(e.wb), word_t'(wb_valid));
            check_value("branch", word_t'(e.taken), word_t'(branch));
            if (e.wb) begin
               check_value("wb_rd", word_t'(e.rd), word_t'(wb_rd));
               check_value("wb_data", e.data, wb_data);
            end
            if (e.taken) begin
               check_value("branch_addr", e.target, branch_addr);
            end
         end else if (wb_valid || branch) begin
            errors++;
            $display("at %0t the DUT raised wb_valid or branch with no instruction due", $time);
         end
      end
   end

endmodule
